/* design/rv_alu.sv */
`timescale 1ns/1ps
// execute-stage alu with zero flag for branch compares
module rv_alu (
	input  logic [rv_pkg::xlen-1:0] a,
	input  logic [rv_pkg::xlen-1:0] b,
	input  rv_pkg::alu_op_t         op,
	output logic [rv_pkg::xlen-1:0] result,
	output logic                    zero
);
	import rv_pkg::*;

	logic signed_lt;

	assign signed_lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_add: result = a + b;
			alu_sub: result = a - b;
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_xor: result = a ^ b;
			alu_slt: result = {{(xlen-1){1'b0}}, signed_lt};
			// shift amount is the low five bits only
			alu_sll: result = a << b[4:0];
			alu_srl: result = a >> b[4:0];
			default: result = '0;
		endcase
	end

	// beq/bne use this after a subtract
	assign zero = (result == '0);

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps
// five-stage in-order rv32i pipeline with forwarding, load-use stall and flushes
module rv_core (
	input  logic                           clk,
	input  logic                           rst_n,
	output logic [rv_pkg::word_addr_w-1:0] imem_addr,
	input  logic [rv_pkg::xlen-1:0]        imem_data,
	output logic                           dmem_read,
	output logic                           dmem_write,
	output logic [rv_pkg::word_addr_w-1:0] dmem_addr,
	output logic [rv_pkg::xlen-1:0]        dmem_wdata,
	input  logic [rv_pkg::xlen-1:0]        dmem_rdata,
	input  logic                           mem_stall
);
	import rv_pkg::*;

	// fetch and fetch/decode
	logic [xlen-1:0] pc;
	logic [xlen-1:0] if_id_instr;
	logic [xlen-1:0] if_id_pc;

	// decode
	logic                  id_reg_write, id_mem_read, id_mem_write, id_alu_src;
	logic                  id_mem_to_reg, id_branch, id_jump;
	alu_op_t               id_alu_op;
	logic [xlen-1:0]       id_imm, id_rs1_data, id_rs2_data, id_jal_target;
	logic [reg_addr_w-1:0] id_rs1, id_rs2, id_rd;

	// decode/execute
	logic                  id_ex_reg_write, id_ex_mem_read, id_ex_mem_write, id_ex_alu_src;
	logic                  id_ex_mem_to_reg, id_ex_branch, id_ex_jump, id_ex_bne;
	alu_op_t               id_ex_alu_op;
	logic [xlen-1:0]       id_ex_rs1_data, id_ex_rs2_data, id_ex_imm, id_ex_pc;
	logic [reg_addr_w-1:0] id_ex_rs1, id_ex_rs2, id_ex_rd;

	// execute
	fwd_sel_t        fwd_a, fwd_b;
	logic [xlen-1:0] ex_src_a, ex_rs2_val, ex_src_b, ex_alu_result;
	logic [xlen-1:0] ex_branch_target, ex_link;
	logic            ex_zero, ex_branch_taken;

	// execute/memory
	logic                  ex_mem_reg_write, ex_mem_mem_read, ex_mem_mem_write;
	logic                  ex_mem_mem_to_reg, ex_mem_jump;
	logic [reg_addr_w-1:0] ex_mem_rd;
	logic [xlen-1:0]       ex_mem_alu, ex_mem_store_data, ex_mem_link, mem_fwd_value;

	// memory/writeback
	logic                  mem_wb_reg_write, mem_wb_mem_to_reg, mem_wb_jump;
	logic [reg_addr_w-1:0] mem_wb_rd;
	logic [xlen-1:0]       mem_wb_alu, mem_wb_rdata, mem_wb_link, wb_data;

	logic load_use_stall, flush_if, flush_ex;

	// ------------------------------
	// fetch
	// ------------------------------
	assign imem_addr = pc[xlen-1:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= reset_pc;
		end else if (!mem_stall) begin
			if (flush_ex)
				pc <= ex_branch_target;
			else if (load_use_stall)
				pc <= pc;
			else if (flush_if)
				pc <= id_jal_target;
			else
				pc <= pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			if_id_instr <= nop_instr;
		end else if (!mem_stall) begin
			if (flush_if) begin
				if_id_instr <= nop_instr;
			end else if (!load_use_stall) begin
				if_id_instr <= imem_data;
				if_id_pc    <= pc;
			end
		end
	end

	// ------------------------------
	// decode
	// ------------------------------
	assign id_rs1 = if_id_instr[19:15];
	assign id_rs2 = if_id_instr[24:20];
	assign id_rd  = if_id_instr[11:7];

	rv_decoder u_decoder (
		.instr      (if_id_instr),
		.reg_write  (id_reg_write),
		.mem_read   (id_mem_read),
		.mem_write  (id_mem_write),
		.alu_src    (id_alu_src),
		.mem_to_reg (id_mem_to_reg),
		.branch     (id_branch),
		.jump       (id_jump),
		.alu_op     (id_alu_op),
		.imm        (id_imm)
	);

	rv_reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.we       (mem_wb_reg_write),
		.rs1      (id_rs1),
		.rs2      (id_rs2),
		.rd       (mem_wb_rd),
		.rd_data  (wb_data),
		.rs1_data (id_rs1_data),
		.rs2_data (id_rs2_data)
	);

	// jal resolves here
	assign id_jal_target = if_id_pc + id_imm;

	always_ff @(posedge clk) begin
		if (!rst_n || (!mem_stall && (flush_ex || load_use_stall))) begin
			id_ex_reg_write  <= 1'b0;
			id_ex_mem_read   <= 1'b0;
			id_ex_mem_write  <= 1'b0;
			id_ex_alu_src    <= 1'b0;
			id_ex_mem_to_reg <= 1'b0;
			id_ex_branch     <= 1'b0;
			id_ex_jump       <= 1'b0;
			id_ex_bne        <= 1'b0;
			id_ex_alu_op     <= alu_add;
		end else if (!mem_stall) begin
			id_ex_reg_write  <= id_reg_write;
			id_ex_mem_read   <= id_mem_read;
			id_ex_mem_write  <= id_mem_write;
			id_ex_alu_src    <= id_alu_src;
			id_ex_mem_to_reg <= id_mem_to_reg;
			id_ex_branch     <= id_branch;
			id_ex_jump       <= id_jump;
			id_ex_bne        <= (if_id_instr[14:12] == f3_bne);
			id_ex_alu_op     <= id_alu_op;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			id_ex_rs1_data <= id_rs1_data;
			id_ex_rs2_data <= id_rs2_data;
			id_ex_imm      <= id_imm;
			id_ex_pc       <= if_id_pc;
			id_ex_rs1      <= id_rs1;
			id_ex_rs2      <= id_rs2;
			id_ex_rd       <= id_rd;
		end
	end

	// ------------------------------
	// execute
	// ------------------------------
	function automatic logic [xlen-1:0] fwd_mux(
		input fwd_sel_t        sel,
		input logic [xlen-1:0] reg_val,
		input logic [xlen-1:0] mem_val,
		input logic [xlen-1:0] wb_val
	);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign ex_src_a   = fwd_mux(fwd_a, id_ex_rs1_data, mem_fwd_value, wb_data);
	assign ex_rs2_val = fwd_mux(fwd_b, id_ex_rs2_data, mem_fwd_value, wb_data);
	assign ex_src_b   = id_ex_alu_src ? id_ex_imm : ex_rs2_val;

	rv_alu u_alu (
		.a      (ex_src_a),
		.b      (ex_src_b),
		.op     (id_ex_alu_op),
		.result (ex_alu_result),
		.zero   (ex_zero)
	);

	assign ex_branch_target = id_ex_pc + id_ex_imm;
	assign ex_link          = id_ex_pc + 32'd4;
	// beq takes on zero, bne on nonzero
	assign ex_branch_taken  = id_ex_branch && (ex_zero ^ id_ex_bne);

	rv_hazard_unit u_hazard (
		.id_rs1          (id_rs1),
		.id_rs2          (id_rs2),
		.ex_rs1          (id_ex_rs1),
		.ex_rs2          (id_ex_rs2),
		.ex_rd           (id_ex_rd),
		.mem_rd          (ex_mem_rd),
		.wb_rd           (mem_wb_rd),
		.ex_mem_read     (id_ex_mem_read),
		.mem_reg_write   (ex_mem_reg_write),
		.wb_reg_write    (mem_wb_reg_write),
		.id_jump         (id_jump),
		.ex_branch_taken (ex_branch_taken),
		.fwd_a           (fwd_a),
		.fwd_b           (fwd_b),
		.load_use_stall  (load_use_stall),
		.flush_if        (flush_if),
		.flush_ex        (flush_ex)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem_reg_write  <= 1'b0;
			ex_mem_mem_read   <= 1'b0;
			ex_mem_mem_write  <= 1'b0;
			ex_mem_mem_to_reg <= 1'b0;
			ex_mem_jump       <= 1'b0;
		end else if (!mem_stall) begin
			ex_mem_reg_write  <= id_ex_reg_write;
			ex_mem_mem_read   <= id_ex_mem_read;
			ex_mem_mem_write  <= id_ex_mem_write;
			ex_mem_mem_to_reg <= id_ex_mem_to_reg;
			ex_mem_jump       <= id_ex_jump;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			ex_mem_rd         <= id_ex_rd;
			ex_mem_alu        <= ex_alu_result;
			ex_mem_store_data <= ex_rs2_val;
			ex_mem_link       <= ex_link;
		end
	end

	// ------------------------------
	// memory and writeback
	// ------------------------------
	assign dmem_read     = ex_mem_mem_read;
	assign dmem_write    = ex_mem_mem_write;
	assign dmem_addr     = ex_mem_alu[xlen-1:2];
	assign dmem_wdata    = ex_mem_store_data;
	// a jal in memory forwards its link, not the alu value
	assign mem_fwd_value = ex_mem_jump ? ex_mem_link : ex_mem_alu;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb_reg_write  <= 1'b0;
			mem_wb_mem_to_reg <= 1'b0;
			mem_wb_jump       <= 1'b0;
		end else if (!mem_stall) begin
			mem_wb_reg_write  <= ex_mem_reg_write;
			mem_wb_mem_to_reg <= ex_mem_mem_to_reg;
			mem_wb_jump       <= ex_mem_jump;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			mem_wb_rd    <= ex_mem_rd;
			mem_wb_alu   <= ex_mem_alu;
			mem_wb_rdata <= dmem_rdata;
			mem_wb_link  <= ex_mem_link;
		end
	end

	assign wb_data = mem_wb_mem_to_reg ? mem_wb_rdata :
		(mem_wb_jump ? mem_wb_link : mem_wb_alu);

	a_dmem_strobes: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmem_read && dmem_write));

endmodule

/* design/rv_decoder.sv */
`timescale 1ns/1ps
// instruction decoder giving control levels, alu operation and sign-extended immediate
module rv_decoder (
	input  logic [rv_pkg::xlen-1:0] instr,
	output logic                    reg_write,
	output logic                    mem_read,
	output logic                    mem_write,
	output logic                    alu_src,
	output logic                    mem_to_reg,
	output logic                    branch,
	output logic                    jump,
	output rv_pkg::alu_op_t         alu_op,
	output logic [rv_pkg::xlen-1:0] imm
);
	import rv_pkg::*;

	logic [2:0] funct3;

	assign funct3 = instr[14:12];

	// shared by r-type and i-type, sub only comes from r-type
	function automatic alu_op_t funct_to_alu(input logic [2:0] f3, input logic sub);
		alu_op_t op;
		case (f3)
			f3_add:  op = sub ? alu_sub : alu_add;
			f3_sll:  op = alu_sll;
			f3_slt:  op = alu_slt;
			f3_xor:  op = alu_xor;
			f3_srl:  op = alu_srl;
			f3_or:   op = alu_or;
			f3_and:  op = alu_and;
			default: op = alu_add;
		endcase
		return op;
	endfunction

	always_comb begin
		// defaults describe a bubble
		reg_write  = 1'b0;
		mem_read   = 1'b0;
		mem_write  = 1'b0;
		alu_src    = 1'b0;
		mem_to_reg = 1'b0;
		branch     = 1'b0;
		jump       = 1'b0;
		alu_op     = alu_add;
		imm        = '0;
		case (opcode_t'(instr[6:0]))
			op_rtype: begin
				reg_write = 1'b1;
				alu_op    = funct_to_alu(funct3, instr[30]);
			end
			op_itype: begin
				reg_write = 1'b1;
				alu_src   = 1'b1;
				alu_op    = funct_to_alu(funct3, 1'b0);
				imm       = {{20{instr[31]}}, instr[31:20]};
			end
			op_load: begin
				reg_write  = 1'b1;
				mem_read   = 1'b1;
				alu_src    = 1'b1;
				mem_to_reg = 1'b1;
				imm        = {{20{instr[31]}}, instr[31:20]};
			end
			op_store: begin
				mem_write = 1'b1;
				alu_src   = 1'b1;
				imm       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			op_branch: begin
				// compare by subtraction, zero flag decides
				branch = 1'b1;
				alu_op = alu_sub;
				imm    = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			op_jal: begin
				reg_write = 1'b1;
				jump      = 1'b1;
				imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			default: ;
		endcase
	end

endmodule

/* design/rv_hazard_unit.sv */
`timescale 1ns/1ps
// forwarding select, load-use stall and flush decisions for the pipeline
module rv_hazard_unit (
	input  logic [rv_pkg::reg_addr_w-1:0] id_rs1,
	input  logic [rv_pkg::reg_addr_w-1:0] id_rs2,
	input  logic [rv_pkg::reg_addr_w-1:0] ex_rs1,
	input  logic [rv_pkg::reg_addr_w-1:0] ex_rs2,
	input  logic [rv_pkg::reg_addr_w-1:0] ex_rd,
	input  logic [rv_pkg::reg_addr_w-1:0] mem_rd,
	input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
	input  logic                          ex_mem_read,
	input  logic                          mem_reg_write,
	input  logic                          wb_reg_write,
	input  logic                          id_jump,
	input  logic                          ex_branch_taken,
	output rv_pkg::fwd_sel_t              fwd_a,
	output rv_pkg::fwd_sel_t              fwd_b,
	output logic                          load_use_stall,
	output logic                          flush_if,
	output logic                          flush_ex
);
	import rv_pkg::*;

	logic load_hit;

	// ------------------------------
	// forwarding
	// ------------------------------
	// memory stage is younger, so it wins over writeback
	function automatic fwd_sel_t fwd_source(
		input logic [reg_addr_w-1:0] src,
		input logic [reg_addr_w-1:0] m_rd,
		input logic                  m_we,
		input logic [reg_addr_w-1:0] w_rd,
		input logic                  w_we
	);
		fwd_sel_t sel;
		if (src == '0)
			sel = fwd_none;
		else if (m_we && m_rd == src)
			sel = fwd_mem;
		else if (w_we && w_rd == src)
			sel = fwd_wb;
		else
			sel = fwd_none;
		return sel;
	endfunction

	assign fwd_a = fwd_source(ex_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
	assign fwd_b = fwd_source(ex_rs2, mem_rd, mem_reg_write, wb_rd, wb_reg_write);

	// ------------------------------
	// stall and flush
	// ------------------------------
	assign load_hit = ex_mem_read && (ex_rd != '0) && (ex_rd == id_rs1 || ex_rd == id_rs2);

	// a taken branch kills the waiting consumer anyway
	assign load_use_stall = load_hit && !ex_branch_taken;
	assign flush_ex       = ex_branch_taken;
	// jal only redirects once it is free to leave decode
	assign flush_if       = ex_branch_taken || (id_jump && !load_use_stall);

endmodule

/* design/rv_pkg.sv */
// shared widths, fixed encodings and enums for the rv32i pipeline core
package rv_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	localparam int xlen        = 32;
	localparam int reg_addr_w  = 5;
	localparam int word_addr_w = 30;

	// fixed values
	localparam logic [xlen-1:0] reset_pc  = 32'h0000_0000;
	// addi x0, x0, 0
	localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

	// funct3 fields of the kept subset
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_srl = 3'b101;
	localparam logic [2:0] f3_or  = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	// beq is the other branch, funct3 zero
	localparam logic [2:0] f3_bne = 3'b001;

	// ------------------------------
	// enums
	// ------------------------------
	typedef enum logic [6:0] {
		op_rtype  = 7'b0110011,
		op_itype  = 7'b0010011,
		op_load   = 7'b0000011,
		op_store  = 7'b0100011,
		op_branch = 7'b1100011,
		op_jal    = 7'b1101111
	} opcode_t;

	typedef enum logic [3:0] {
		alu_add = 4'd0,
		alu_sub = 4'd1,
		alu_and = 4'd2,
		alu_or  = 4'd3,
		alu_xor = 4'd4,
		alu_slt = 4'd5,
		alu_sll = 4'd6,
		alu_srl = 4'd7
	} alu_op_t;

	// operand source in execute
	typedef enum logic [1:0] {
		fwd_none = 2'b00,
		fwd_wb   = 2'b01,
		fwd_mem  = 2'b10
	} fwd_sel_t;

endpackage

/* design/rv_reg_file.sv */
`timescale 1ns/1ps
// 32-entry register file, x0 stays zero, reads see the same-cycle write
module rv_reg_file (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          we,
	input  logic [rv_pkg::reg_addr_w-1:0] rs1,
	input  logic [rv_pkg::reg_addr_w-1:0] rs2,
	input  logic [rv_pkg::reg_addr_w-1:0] rd,
	input  logic [rv_pkg::xlen-1:0]       rd_data,
	output logic [rv_pkg::xlen-1:0]       rs1_data,
	output logic [rv_pkg::xlen-1:0]       rs2_data
);
	import rv_pkg::*;

	logic [xlen-1:0] regs [0:(1<<reg_addr_w)-1];
	logic            wr_active;

	// writes to x0 are dropped here
	assign wr_active = we && (rd != '0);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < (1 << reg_addr_w); i++)
				regs[i] <= '0;
		end else if (wr_active) begin
			regs[rd] <= rd_data;
		end
	end

	// write-first bypass
	assign rs1_data = (wr_active && rd == rs1) ? rd_data : regs[rs1];
	assign rs2_data = (wr_active && rd == rs2) ? rd_data : regs[rs2];

	a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(rs1 != '0 || rs1_data == '0) && (rs2 != '0 || rs2_data == '0));

endmodule

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rv_core -f src.f -o sim_rv_core &&
./obj_dir/sim_rv_core | tee /dev/stderr | grep -q "All tests passed" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* src.f */
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_reg_file.sv
design/rv_alu.sv
design/rv_hazard_unit.sv
design/rv_core.sv
test/tb_rv_core.sv

/* test/tb_rv_core.sv */
`timescale 1ns/1ps
// testbench for the pipeline core: programs, memories, reference interpreter and store checks
module tb_rv_core;

	logic        clk, rst_n, mem_stall;
	logic [29:0] imem_addr, dmem_addr;
	logic [31:0] imem_data, dmem_wdata, dmem_rdata;
	logic        dmem_read, dmem_write;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] prog [$];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	string       cur_test;
	int          got, store_fails, test_fails, tests_passed, tests_failed;
	int          exp_loads, loads_seen;
	logic [31:0] rng;

	localparam logic [31:0] jal_self = 32'h0000_006f;

	rv_core UUT (
		.clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_data(imem_data),
		.dmem_read(dmem_read), .dmem_write(dmem_write), .dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .mem_stall(mem_stall)
	);

	assign imem_data  = imem[imem_addr[7:0]];
	assign dmem_rdata = dmem[dmem_addr[7:0]];

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// initial data memory, every byte tied to the address
	function automatic logic [31:0] fill_word(input logic [7:0] a);
		return {a, ~a, a ^ 8'h5a, a + 8'h3c};
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual, inout int fails);
		if (expected !== actual) begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			fails++;
		end
	endtask

	// instruction encoders
	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b010, rd, 7'b0000011};
	endfunction

	function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// ------------------------------
	// reference interpreter
	// ------------------------------
	function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic sub,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return sub ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return {31'b0, $signed(a) < $signed(b)};
			3'b100:  return a ^ b;
			3'b101:  return a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic int ref_model();
		logic [31:0] x [0:31];
		logic [31:0] dm [0:255];
		logic [31:0] pc, ins, a, b, v, imm_i, imm_s, addr;
		logic [4:0]  rd;
		int          steps;
		for (int i = 0; i < 32; i++)
			x[i] = '0;
		for (int i = 0; i < 256; i++)
			dm[i] = fill_word(8'(i));
		exp_addr.delete();
		exp_data.delete();
		exp_loads = 0;
		pc = '0;
		steps = 0;
		while (imem[pc[9:2]] != jal_self && steps < 4000) begin
			ins   = imem[pc[9:2]];
			a     = x[ins[19:15]];
			b     = x[ins[24:20]];
			rd    = ins[11:7];
			imm_i = {{20{ins[31]}}, ins[31:20]};
			imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			v     = 'x;
			case (ins[6:0])
				7'b0110011: v = ref_alu(ins[14:12], ins[30], a, b);
				7'b0010011: v = ref_alu(ins[14:12], 1'b0, a, imm_i);
				7'b0000011: begin
					v = dm[8'((a + imm_i) >> 2)];
					exp_loads++;
				end
				7'b0100011: begin
					addr = a + imm_s;
					dm[addr[9:2]] = b;
					exp_addr.push_back({2'b00, addr[31:2]});
					exp_data.push_back(b);
				end
				7'b1100011: begin
					if ((ins[14:12] == 3'b000) ? (a == b) : (a != b)) begin
						pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
							ins[11:8], 1'b0} - 32'd4;
					end
				end
				default: begin
					// jal
					v  = pc + 32'd4;
					pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
						ins[30:21], 1'b0} - 32'd4;
				end
			endcase
			if (ins[6:0] != 7'b0100011 && ins[6:0] != 7'b1100011 && rd != 5'd0)
				x[rd] = v;
			pc = pc + 32'd4;
			steps++;
		end
		return exp_addr.size();
	endfunction

	// ------------------------------
	// store compare
	// ------------------------------
	always @(posedge clk) begin
		if (!rst_n) begin
			got <= 0;
			loads_seen <= 0;
			for (int i = 0; i < 256; i++)
				dmem[i] <= fill_word(8'(i));
		end else if (!mem_stall) begin
			if (dmem_read)
				loads_seen <= loads_seen + 1;
			if (dmem_write) begin
				if (got < exp_addr.size()) begin
					check({cur_test, " store address"}, exp_addr[got], {2'b00, dmem_addr},
						store_fails);
					check({cur_test, " store data"}, exp_data[got], dmem_wdata,
						store_fails);
				end else begin
					$display("test %s: store to word %h beyond the expected list",
						cur_test, dmem_addr);
					store_fails++;
				end
				dmem[dmem_addr[7:0]] <= dmem_wdata;
				got <= got + 1;
			end
		end
	end

	// ------------------------------
	// programs
	// ------------------------------
	task automatic build_alu_chain();
		prog = {};
		prog.push_back(enc_i(3'b000, 5'd1, 5'd0, 12'd5));
		prog.push_back(enc_i(3'b000, 5'd2, 5'd1, 12'(-3)));
		prog.push_back(enc_r(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
		prog.push_back(enc_sw(5'd3, 5'd0, 12'd0));
		prog.push_back(enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
		prog.push_back(enc_sw(5'd4, 5'd0, 12'd4));
		prog.push_back(enc_r(7'h00, 3'b111, 5'd5, 5'd3, 5'd4));
		prog.push_back(enc_r(7'h00, 3'b110, 5'd6, 5'd5, 5'd2));
		prog.push_back(enc_sw(5'd6, 5'd0, 12'd8));
		prog.push_back(enc_r(7'h00, 3'b100, 5'd7, 5'd6, 5'd3));
		prog.push_back(enc_i(3'b000, 5'd9, 5'd0, 12'(-7)));
		prog.push_back(enc_r(7'h00, 3'b010, 5'd10, 5'd9, 5'd1));
		prog.push_back(enc_sw(5'd10, 5'd0, 12'd12));
		prog.push_back(enc_r(7'h00, 3'b001, 5'd11, 5'd1, 5'd2));
		prog.push_back(enc_r(7'h00, 3'b101, 5'd12, 5'd11, 5'd4));
		prog.push_back(enc_sw(5'd11, 5'd0, 12'd16));
		prog.push_back(enc_sw(5'd12, 5'd0, 12'd20));
		prog.push_back(enc_i(3'b111, 5'd13, 5'd12, 12'd6));
		prog.push_back(enc_i(3'b110, 5'd14, 5'd13, 12'h100));
		prog.push_back(enc_i(3'b100, 5'd15, 5'd14, 12'hfff));
		prog.push_back(enc_i(3'b010, 5'd16, 5'd15, 12'd0));
		prog.push_back(enc_sw(5'd13, 5'd0, 12'd24));
		prog.push_back(enc_sw(5'd14, 5'd0, 12'd28));
		prog.push_back(enc_sw(5'd15, 5'd0, 12'd32));
		prog.push_back(enc_sw(5'd16, 5'd0, 12'd36));
		prog.push_back(enc_sw(5'd7, 5'd0, 12'd40));
		prog.push_back(enc_r(7'h00, 3'b101, 5'd17, 5'd9, 5'd2));
		prog.push_back(enc_sw(5'd17, 5'd0, 12'd44));
		prog.push_back(enc_sw(5'd5, 5'd0, 12'd48));
		prog.push_back(jal_self);
	endtask

	task automatic build_load_use();
		prog = {};
		prog.push_back(enc_i(3'b000, 5'd1, 5'd0, 12'd16));
		prog.push_back(enc_lw(5'd2, 5'd1, 12'd0));
		prog.push_back(enc_r(7'h00, 3'b000, 5'd3, 5'd2, 5'd2));
		prog.push_back(enc_sw(5'd3, 5'd0, 12'd8));
		prog.push_back(enc_lw(5'd4, 5'd0, 12'd8));
		prog.push_back(enc_sw(5'd4, 5'd0, 12'd12));
		prog.push_back(enc_lw(5'd5, 5'd1, 12'd4));
		prog.push_back(enc_i(3'b100, 5'd6, 5'd5, 12'h0f0));
		prog.push_back(enc_sw(5'd6, 5'd1, 12'd8));
		prog.push_back(jal_self);
	endtask

	task automatic build_branches();
		prog = {};
		prog.push_back(enc_i(3'b000, 5'd1, 5'd0, 12'd3));
		prog.push_back(enc_i(3'b000, 5'd2, 5'd0, 12'd3));
		prog.push_back(enc_b(3'b000, 5'd1, 5'd2, 13'd8));
		prog.push_back(enc_sw(5'd1, 5'd0, 12'h20));
		prog.push_back(enc_sw(5'd2, 5'd0, 12'h24));
		prog.push_back(enc_b(3'b001, 5'd1, 5'd2, 13'd8));
		prog.push_back(enc_sw(5'd1, 5'd0, 12'h28));
		prog.push_back(enc_b(3'b000, 5'd1, 5'd0, 13'd8));
		prog.push_back(enc_sw(5'd2, 5'd0, 12'h2c));
		prog.push_back(enc_i(3'b000, 5'd3, 5'd0, 12'd7));
		prog.push_back(enc_b(3'b001, 5'd3, 5'd1, 13'd12));
		prog.push_back(enc_sw(5'd3, 5'd0, 12'h30));
		prog.push_back(enc_sw(5'd3, 5'd0, 12'h34));
		prog.push_back(enc_sw(5'd1, 5'd0, 12'h38));
		prog.push_back(jal_self);
	endtask

	task automatic build_jal();
		prog = {};
		prog.push_back(enc_i(3'b000, 5'd1, 5'd0, 12'd1));
		prog.push_back(enc_jal(5'd5, 21'd8));
		prog.push_back(enc_sw(5'd1, 5'd0, 12'h40));
		prog.push_back(enc_sw(5'd5, 5'd0, 12'h44));
		prog.push_back(enc_jal(5'd6, 21'd8));
		prog.push_back(enc_i(3'b000, 5'd7, 5'd0, 12'd1));
		prog.push_back(enc_r(7'h00, 3'b000, 5'd8, 5'd6, 5'd5));
		prog.push_back(enc_sw(5'd8, 5'd0, 12'h48));
		prog.push_back(enc_sw(5'd7, 5'd0, 12'h4c));
		prog.push_back(jal_self);
	endtask

	// ------------------------------
	// test runner
	// ------------------------------
	task automatic run_program(input string name, input bit stalls);
		int n_exp, cycles, stall_cycles, fails_before;
		logic st;
		cur_test = name;
		@(posedge clk);
		rst_n     <= 1'b0;
		mem_stall <= 1'b0;
		for (int i = 0; i < 256; i++)
			imem[i] = (i < prog.size()) ? prog[i] : jal_self;
		n_exp = ref_model();
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		#1;
		fails_before = test_fails + store_fails;
		// first cycle out of reset
		check({name, " reset imem_addr"}, 32'd0, {2'b00, imem_addr}, test_fails);
		check({name, " reset dmem_read"}, 32'd0, {31'b0, dmem_read}, test_fails);
		check({name, " reset dmem_write"}, 32'd0, {31'b0, dmem_write}, test_fails);
		cycles = 0;
		stall_cycles = 0;
		while (got < n_exp && cycles < 4 * prog.size() + stall_cycles + 64) begin
			@(posedge clk);
			cycles++;
			if (stalls) begin
				rng = xorshift(rng);
				st = (rng[1:0] == 2'b00);
				mem_stall <= st;
				stall_cycles += int'(st);
			end
		end
		if (got < n_exp) begin
			$display("test %s: ran out of cycles after %0d with %0d of %0d stores seen",
				name, cycles, got, n_exp);
			test_fails++;
		end
		mem_stall <= 1'b0;
		// leave room for any extra store to show up
		repeat (12) @(posedge clk);
		check({name, " load count"}, exp_loads, loads_seen, test_fails);
		if (test_fails + store_fails == fails_before) begin
			$display("test %s: pass, %0d stores in %0d cycles", name, n_exp, cycles);
			tests_passed++;
		end else begin
			$display("test %s: fail", name);
			tests_failed++;
		end
	endtask

	initial begin
		rst_n        = 1'b0;
		mem_stall    = 1'b0;
		store_fails  = 0;
		test_fails   = 0;
		tests_passed = 0;
		tests_failed = 0;
		rng          = 32'h94a1;
		build_alu_chain();
		run_program("alu_chain", 1'b0);
		build_load_use();
		run_program("load_use", 1'b0);
		build_branches();
		run_program("branches", 1'b0);
		build_jal();
		run_program("jal_link", 1'b0);
		build_alu_chain();
		run_program("alu_chain_stalled", 1'b1);
		$display("tests run %0d, passed %0d, failed %0d, check errors %0d",
			tests_passed + tests_failed, tests_passed, tests_failed,
			test_fails + store_fails);
		if (tests_failed == 0 && test_fails + store_fails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule
